// File: design/gpio_bank.sv
`timescale 1ns/1ps
`default_nettype none

// Output port with data register and optional direction register
// Direction bit 1 drives the pin, 0 leaves it as input
module gpio_bank #(
  parameter int WIDTH       = 8,
  parameter int DATA_BIT    = 0,    // Address bit of the data register
  parameter int DIR_BIT     = 1,    // Address bit of the direction register
  parameter bit OUTPUT_ONLY = 1'b0  // No direction register, always driven
) (
  input  wire                  clk,
  input  wire                  resetq,
  input  wire j4_io_pkg::io_req_t staged,
  input  wire [WIDTH-1:0]      pin_in,
  output logic [WIDTH-1:0]     pin_out,
  output logic [WIDTH-1:0]     pin_oe,
  output logic [WIDTH-1:0]     data_rd,
  output logic [WIDTH-1:0]     dir_rd
);

  logic data_we;

  assign data_we = staged.wr & staged.addr[DATA_BIT];

  // Output level register
  always_ff @(posedge clk) begin
    if (!resetq)
      pin_out <= '0;
    else if (data_we)
      pin_out <= staged.data[WIDTH-1:0]; // Low bits of the write word
  end

  generate
    if (OUTPUT_ONLY) begin : g_out_only
      assign pin_oe = '1; // Always driving
      assign dir_rd = '1;
    end else begin : g_dir
      logic             dir_we;
      logic [WIDTH-1:0] dir_q;

      assign dir_we = staged.wr & staged.addr[DIR_BIT];

      always_ff @(posedge clk) begin
        if (!resetq)
          dir_q <= '0; // All inputs after reset
        else if (dir_we)
          dir_q <= staged.data[WIDTH-1:0];
      end

      assign pin_oe = dir_q;
      assign dir_rd = dir_q;
    end
  endgenerate

  // Effective pin level, own drive where enabled, outside level elsewhere
  assign data_rd = (pin_out & pin_oe) | (pin_in & ~pin_oe);

endmodule

`default_nettype wire

// File: design/io_bus_stage.sv
`timescale 1ns/1ps
`default_nettype none

// One cycle delay of the CPU I/O request, read data follows from the staged copy
module io_bus_stage (
  input  wire                  clk,
  input  wire                  resetq,
  input  wire j4_io_pkg::io_req_t req,
  output j4_io_pkg::io_req_t   staged
);

  logic strobe; // Any access this cycle

  assign strobe = req.rd | req.wr;

  always_ff @(posedge clk) begin
    if (!resetq) begin
      staged.rd   <= 1'b0;
      staged.wr   <= 1'b0;
      staged.addr <= '0; // Nothing selected out of reset
    end else begin
      staged.rd <= req.rd;
      staged.wr <= req.wr;
      // Idle cycles select no device at all
      if (strobe)
        staged.addr <= req.addr;
      else
        staged.addr <= '0;
    end
  end

  // Payload just follows
  always_ff @(posedge clk) begin
    staged.data <= req.data;
    staged.slot <= req.slot;
  end

endmodule

`default_nettype wire

// File: design/io_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "j4_io_macros.svh"

// I/O read data, OR of every selected device
module io_read_mux (
  input  wire j4_io_pkg::io_req_t    staged,
  input  wire [`J4_IO_PORT_W-1:0]   pmod_in,
  input  wire [`J4_IO_PORT_W-1:0]   pmod_dir,
  input  wire [`J4_IO_PORT_W-1:0]   leds,
  input  wire [`J4_IO_PORT_W-1:0]   hdr1_in,
  input  wire [`J4_IO_PORT_W-1:0]   hdr1_dir,
  input  wire [`J4_IO_PORT_W-1:0]   hdr2_in,
  input  wire [`J4_IO_PORT_W-1:0]   hdr2_dir,
  input  wire [`J4_IO_MISC_W-1:0]   misc_out,
  input  wire                       flash_miso,
  input  wire j4_io_pkg::word_t     task_rd,
  output j4_io_pkg::word_t          io_din
);

  j4_io_pkg::word_t misc_in; // UART bits stay zero
  j4_io_pkg::word_t slot_id;

  assign misc_in = j4_io_pkg::word_t'(flash_miso) << `J4_IO_MISO_POS;
  assign slot_id = j4_io_pkg::word_t'(staged.slot);

  // Keep a zero-extended value only when its bit is selected
  function automatic j4_io_pkg::word_t pick(input logic sel, input j4_io_pkg::word_t val);
    return sel ? val : '0;
  endfunction

  always_comb begin
    io_din = task_rd; // Gated inside the task table
    io_din |= pick(staged.addr[`BIT_PMOD],     j4_io_pkg::word_t'(pmod_in));
    io_din |= pick(staged.addr[`BIT_PMOD_DIR], j4_io_pkg::word_t'(pmod_dir));
    io_din |= pick(staged.addr[`BIT_LEDS],     j4_io_pkg::word_t'(leds));
    io_din |= pick(staged.addr[`BIT_MISC_OUT], j4_io_pkg::word_t'(misc_out));
    io_din |= pick(staged.addr[`BIT_HDR1],     j4_io_pkg::word_t'(hdr1_in));
    io_din |= pick(staged.addr[`BIT_HDR1_DIR], j4_io_pkg::word_t'(hdr1_dir));
    io_din |= pick(staged.addr[`BIT_HDR2],     j4_io_pkg::word_t'(hdr2_in));
    io_din |= pick(staged.addr[`BIT_HDR2_DIR], j4_io_pkg::word_t'(hdr2_dir));
    io_din |= pick(staged.addr[`BIT_MISC_IN],  misc_in);
    io_din |= pick(staged.addr[`BIT_SLOT_ID],  slot_id); // Who is asking
  end

endmodule

`default_nettype wire

// File: design/j4_io_macros.svh
`ifndef J4_IO_MACROS_SVH
`define J4_IO_MACROS_SVH

// Bus and port widths
`define J4_IO_WORD_W 16 // I/O data word and address
`define J4_IO_PORT_W 8  // GPIO and LED ports
`define J4_IO_MISC_W 3  // Misc output register
`define J4_IO_SLOTS  4  // CPU slots, slot 0 has no task word

// One-hot I/O address bits
`define BIT_PMOD       0
`define BIT_PMOD_DIR   1
`define BIT_LEDS       2
`define BIT_MISC_OUT   3
`define BIT_HDR1       4
`define BIT_HDR1_DIR   5
`define BIT_HDR2       6
`define BIT_HDR2_DIR   7
`define BIT_TASK1      8  // Task words for slots 1..3 sit on bits 8..10
`define BIT_TASK2      9
`define BIT_TASK3      10
`define BIT_MISC_IN    13
`define BIT_TASK_FETCH 14 // Read fetches own task, write kills slots
`define BIT_SLOT_ID    15

`define J4_IO_MISO_POS 2 // Flash MISO inside the misc input word

`endif

// File: design/j4_io_pkg.sv
`default_nettype none

`include "j4_io_macros.svh"

package j4_io_pkg;

  // I/O data or address word
  typedef logic [`J4_IO_WORD_W-1:0] word_t;

  // Slot number, 0..3
  typedef logic [$clog2(`J4_IO_SLOTS)-1:0] slot_t;

  // Kill request, one bit per slot, bit n kills slot n
  typedef logic [`J4_IO_SLOTS-1:0] kill_t;

  // One CPU I/O request
  typedef struct packed {
    logic  rd;   // Read strobe, one cycle
    logic  wr;   // Write strobe, one cycle
    word_t addr; // One-hot device select
    word_t data; // Write data
    slot_t slot; // Requesting slot
  } io_req_t;

endpackage

`default_nettype wire

// File: design/j4_io_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "j4_io_macros.svh"

// I/O subsystem beside the J4 CPU
module j4_io_top (
  input  wire                       clk,
  input  wire                       resetq,
  input  wire j4_io_pkg::io_req_t   io_req,
  output wire j4_io_pkg::word_t     io_din,
  input  wire [`J4_IO_PORT_W-1:0]   pmod_in,
  output wire [`J4_IO_PORT_W-1:0]   pmod_out,
  output wire [`J4_IO_PORT_W-1:0]   pmod_oe,
  input  wire [`J4_IO_PORT_W-1:0]   hdr1_in,
  output wire [`J4_IO_PORT_W-1:0]   hdr1_out,
  output wire [`J4_IO_PORT_W-1:0]   hdr1_oe,
  input  wire [`J4_IO_PORT_W-1:0]   hdr2_in,
  output wire [`J4_IO_PORT_W-1:0]   hdr2_out,
  output wire [`J4_IO_PORT_W-1:0]   hdr2_oe,
  output wire [`J4_IO_PORT_W-1:0]   leds,
  output wire [`J4_IO_MISC_W-1:0]   misc_out,
  input  wire                       flash_miso,
  output wire j4_io_pkg::kill_t     kill_slot_rq
);

  wire j4_io_pkg::io_req_t  staged;
  wire [`J4_IO_PORT_W-1:0]  pmod_rd, pmod_dir;
  wire [`J4_IO_PORT_W-1:0]  hdr1_rd, hdr1_dir;
  wire [`J4_IO_PORT_W-1:0]  hdr2_rd, hdr2_dir;
  wire [`J4_IO_PORT_W-1:0]  leds_rd;
  wire [`J4_IO_MISC_W-1:0]  misc_rd;
  wire j4_io_pkg::word_t    task_rd;

  io_bus_stage i_stage (.clk, .resetq, .req(io_req), .staged);

  gpio_bank #(.WIDTH(`J4_IO_PORT_W), .DATA_BIT(`BIT_PMOD), .DIR_BIT(`BIT_PMOD_DIR)) i_pmod (
    .clk, .resetq, .staged, .pin_in(pmod_in), .pin_out(pmod_out), .pin_oe(pmod_oe),
    .data_rd(pmod_rd), .dir_rd(pmod_dir));

  gpio_bank #(.WIDTH(`J4_IO_PORT_W), .DATA_BIT(`BIT_HDR1), .DIR_BIT(`BIT_HDR1_DIR)) i_hdr1 (
    .clk, .resetq, .staged, .pin_in(hdr1_in), .pin_out(hdr1_out), .pin_oe(hdr1_oe),
    .data_rd(hdr1_rd), .dir_rd(hdr1_dir));

  gpio_bank #(.WIDTH(`J4_IO_PORT_W), .DATA_BIT(`BIT_HDR2), .DIR_BIT(`BIT_HDR2_DIR)) i_hdr2 (
    .clk, .resetq, .staged, .pin_in(hdr2_in), .pin_out(hdr2_out), .pin_oe(hdr2_oe),
    .data_rd(hdr2_rd), .dir_rd(hdr2_dir));

  // LEDs and misc out are always driven, no input level
  gpio_bank #(.WIDTH(`J4_IO_PORT_W), .DATA_BIT(`BIT_LEDS), .OUTPUT_ONLY(1'b1)) i_leds (
    .clk, .resetq, .staged, .pin_in('0), .pin_out(leds), .pin_oe(),
    .data_rd(leds_rd), .dir_rd());

  gpio_bank #(.WIDTH(`J4_IO_MISC_W), .DATA_BIT(`BIT_MISC_OUT), .OUTPUT_ONLY(1'b1)) i_misc (
    .clk, .resetq, .staged, .pin_in('0), .pin_out(misc_out), .pin_oe(),
    .data_rd(misc_rd), .dir_rd());

  task_slots i_tasks (.clk, .resetq, .staged, .rd_word(task_rd), .kill_slot_rq);

  io_read_mux i_rd_mux (
    .staged,
    .pmod_in   (pmod_rd),
    .pmod_dir,
    .leds      (leds_rd),
    .hdr1_in   (hdr1_rd),
    .hdr1_dir,
    .hdr2_in   (hdr2_rd),
    .hdr2_dir,
    .misc_out  (misc_rd),
    .flash_miso,
    .task_rd,
    .io_din
  );

endmodule

`default_nettype wire

// File: design/task_slots.sv
`timescale 1ns/1ps
`default_nettype none

`include "j4_io_macros.svh"

// Task table for slots 1..3
// Any slot can set any task word, each slot fetches only its own
// A fetched word with bit 0 set runs once and is cleared
module task_slots (
  input  wire                  clk,
  input  wire                  resetq,
  input  wire j4_io_pkg::io_req_t staged,
  output j4_io_pkg::word_t     rd_word,
  output j4_io_pkg::kill_t     kill_slot_rq
);

  localparam int NSLOT = `J4_IO_SLOTS;

  j4_io_pkg::word_t task_q [1:NSLOT-1]; // Slot 0 has no entry
  j4_io_pkg::word_t fetch_word;         // Own task with run-once bit masked
  logic             fetch_rd;
  logic             kill_wr;

  assign fetch_rd = staged.rd & staged.addr[`BIT_TASK_FETCH];
  assign kill_wr  = staged.wr & staged.addr[`BIT_TASK_FETCH];

  // Look up the requesting slot's word
  always_comb begin
    fetch_word = '0; // Slot 0 always starts from zero
    for (int s = 1; s < NSLOT; s++) begin
      if (staged.slot == j4_io_pkg::slot_t'(s))
        fetch_word = {task_q[s][`J4_IO_WORD_W-1:1], 1'b0}; // Valid XTs are even
    end
  end

  // Read data, already gated by own address bits
  always_comb begin
    rd_word = staged.addr[`BIT_TASK_FETCH] ? fetch_word : '0;
    for (int s = 1; s < NSLOT; s++) begin
      if (staged.addr[`BIT_TASK1 + s - 1])
        rd_word = rd_word | task_q[s]; // Plain read, run-once bit kept
    end
  end

  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int s = 1; s < NSLOT; s++)
        task_q[s] <= '0; // Reset stops every task slot
      kill_slot_rq <= '0;
    end else begin
      // Pulse only, drops again on the next edge
      kill_slot_rq <= kill_wr ? staged.data[NSLOT-1:0] : '0;
      for (int s = 1; s < NSLOT; s++) begin
        if (staged.wr && staged.addr[`BIT_TASK1 + s - 1])
          task_q[s] <= staged.data;
        else if (fetch_rd && staged.slot == j4_io_pkg::slot_t'(s) && task_q[s][0])
          task_q[s] <= '0; // Run-once task consumed
      end
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the J4 I/O testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module j4_io_tb \
  -f src.f -o j4_io_sim

# The simulator exits nonzero on failure, the log decides
./obj_dir/j4_io_sim > sim.log 2>&1 || true
cat sim.log
grep -q "PASS: all tests" sim.log

// File: src.f
+incdir+design
design/j4_io_pkg.sv
design/io_bus_stage.sv
design/gpio_bank.sv
design/task_slots.sv
design/io_read_mux.sv
design/j4_io_top.sv
verification/j4_io_checker.sv
verification/j4_io_tb.sv

// File: verification/j4_io_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "j4_io_macros.svh"

// Bus and reset properties of the I/O subsystem, bound into the top level
module j4_io_checker (
  input wire                     clk,
  input wire                     resetq,
  input wire j4_io_pkg::io_req_t io_req,
  input wire j4_io_pkg::word_t   io_din,
  input wire j4_io_pkg::kill_t   kill_slot_rq,
  input wire [`J4_IO_PORT_W-1:0] pmod_oe,
  input wire [`J4_IO_PORT_W-1:0] hdr1_oe,
  input wire [`J4_IO_PORT_W-1:0] hdr2_oe
);

  int unsigned fail_cnt = 0; // Failed assertions so far

  // Kill request never lasts longer than one cycle
  a_kill_pulse: assert property (@(posedge clk) disable iff (!resetq)
    kill_slot_rq != '0 |=> kill_slot_rq == '0)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("kill_slot_rq nonzero in two cycles in a row");
    end

  // No strobe sampled, so nothing selected in the staged cycle
  a_idle_din: assert property (@(posedge clk) disable iff (!resetq)
    !(io_req.rd || io_req.wr) |=> io_din == '0)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("io_din nonzero after a cycle without strobe");
    end

  // Reset leaves every GPIO pin as input
  a_reset_oe: assert property (@(posedge clk)
    !resetq |=> pmod_oe == '0 && hdr1_oe == '0 && hdr2_oe == '0)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("GPIO output enable set right after reset");
    end

endmodule

bind j4_io_top j4_io_checker i_checker (
  .clk, .resetq, .io_req, .io_din, .kill_slot_rq, .pmod_oe, .hdr1_oe, .hdr2_oe);

`default_nettype wire

// File: verification/j4_io_stimulus.txt
# op slot bit data expect; slot, data, expect in hex, bit in decimal
# W write, R read, G pin readback, P random pins, O port out/oe, K kill, F miso, N idle
O 0 0 00 00
O 0 4 00 00
O 0 6 00 00
O 0 2 00 00
O 0 3 00 00
K 0 0 0 0
R 0 8 0 0
R 0 9 0 0
R 0 10 0 0
W 1 0 a5 0
W 1 1 f0 0
P 0 0 0 0
G 1 0 0 0
R 1 1 0 f0
O 0 0 a5 f0
W 2 4 3c 0
W 2 5 0f 0
P 0 4 0 0
G 2 4 0 0
W 3 6 ff 0
W 3 7 55 0
P 0 6 0 0
G 3 6 0 0
O 0 6 ff 55
W 0 2 c3 0
R 0 2 0 c3
O 0 2 c3 0
W 0 3 fe 0
R 0 3 0 6
O 0 3 06 0
F 0 0 1 0
R 0 13 0 4
R 2 15 0 2
W 0 8 1235 0
W 0 9 2468 0
W 0 10 ace1 0
R 1 14 0 1234
R 1 14 0 0
R 2 14 0 2468
R 2 14 0 2468
R 3 14 0 ace0
R 0 14 0 0
W 0 14 5 0
K 0 0 0 5
N 0 0 6 0

// File: verification/j4_io_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "j4_io_macros.svh"

module j4_io_tb;

  localparam int MAX_LINES = 200; // Upper bound on stimulus lines

  logic                     clk = 1'b0;
  logic                     resetq;
  j4_io_pkg::io_req_t       io_req;
  j4_io_pkg::word_t         io_din;
  logic [`J4_IO_PORT_W-1:0] pmod_in, pmod_out, pmod_oe;
  logic [`J4_IO_PORT_W-1:0] hdr1_in, hdr1_out, hdr1_oe;
  logic [`J4_IO_PORT_W-1:0] hdr2_in, hdr2_out, hdr2_oe;
  logic [`J4_IO_PORT_W-1:0] leds;
  logic [`J4_IO_MISC_W-1:0] misc_out;
  logic                     flash_miso;
  j4_io_pkg::kill_t         kill_slot_rq;

  logic [31:0]              lfsr = 32'hf507;
  logic [`J4_IO_PORT_W-1:0] out_m [3]; // Model of PMOD, HDR1, HDR2
  logic [`J4_IO_PORT_W-1:0] dir_m [3];
  logic [`J4_IO_PORT_W-1:0] pin_m [3];

  always #5 clk = ~clk;

  j4_io_top i_dut (.*);

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input j4_io_pkg::word_t got, input j4_io_pkg::word_t want,
                            input string what);
    if (got !== want)
      abort_run($sformatf("ERR %0t %s: got %h expected %h", $time, what, got, want));
  endtask

  task automatic check_port(input logic [`J4_IO_PORT_W-1:0] got,
                            input logic [`J4_IO_PORT_W-1:0] want, input string what);
    if (got !== want)
      abort_run($sformatf("ERR %0t %s: got %h expected %h", $time, what, got, want));
  endtask

  task automatic check_kill(input j4_io_pkg::kill_t got, input j4_io_pkg::kill_t want,
                            input string what);
    if (got !== want)
      abort_run($sformatf("ERR %0t %s: got %h expected %h", $time, what, got, want));
  endtask

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic random_byte(output logic [7:0] v);
    for (int i = 0; i < 8; i++) begin
      v[i] = lfsr[0]; // One step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Bits 0/1 PMOD, 4/5 HDR1, 6/7 HDR2
  function automatic int port_of(input int bitn);
    return bitn < 4 ? 0 : (bitn < 6 ? 1 : 2);
  endfunction

  // Expected pin level, bit by bit from the model
  function automatic logic [`J4_IO_PORT_W-1:0] pin_level(input int p);
    logic [`J4_IO_PORT_W-1:0] v;
    for (int i = 0; i < `J4_IO_PORT_W; i++)
      v[i] = dir_m[p][i] ? out_m[p][i] : pin_m[p][i]; // Output bit drives the pin
    return v;
  endfunction

  // Drive and enable of one GPIO port against the model
  task automatic verify_gpio_pins(input int p);
    case (p)
      0: begin
        check_port(pmod_out, out_m[0], "PMOD out");
        check_port(pmod_oe, dir_m[0], "PMOD oe");
      end
      1: begin
        check_port(hdr1_out, out_m[1], "HDR1 out");
        check_port(hdr1_oe, dir_m[1], "HDR1 oe");
      end
      default: begin
        check_port(hdr2_out, out_m[2], "HDR2 out");
        check_port(hdr2_oe, dir_m[2], "HDR2 oe");
      end
    endcase
  endtask

  // Strobe from one falling edge to the next, then wait for edge 1
  task automatic bus_write(input j4_io_pkg::slot_t slot, input int bitn,
                           input j4_io_pkg::word_t data);
    io_req.addr = j4_io_pkg::word_t'(1) << bitn;
    io_req.data = data;
    io_req.slot = slot;
    io_req.wr   = 1'b1;
    @(posedge clk); // Edge 0
    @(negedge clk);
    io_req.wr = 1'b0;
    @(posedge clk); // Edge 1, write target updates
    @(negedge clk);
  endtask

  task automatic bus_read(input j4_io_pkg::slot_t slot, input int bitn,
                          output j4_io_pkg::word_t data);
    io_req.addr = j4_io_pkg::word_t'(1) << bitn;
    io_req.slot = slot;
    io_req.rd   = 1'b1;
    @(posedge clk);
    @(negedge clk);
    data      = io_din; // One cycle latency
    io_req.rd = 1'b0;
  endtask

  initial begin
    int                       fd;
    int                       n;
    int                       lines;
    int                       bitn;
    int                       p;
    string                    line;
    logic [7:0]               op;
    j4_io_pkg::slot_t         slot;
    j4_io_pkg::word_t         data;
    j4_io_pkg::word_t         want;
    j4_io_pkg::word_t         got;
    logic [`J4_IO_PORT_W-1:0] pins;
    logic [`J4_IO_PORT_W-1:0] pins_hi;

    resetq     = 1'b0;
    io_req     = '0;
    pmod_in    = '0;
    hdr1_in    = '0;
    hdr2_in    = '0;
    flash_miso = 1'b0;
    for (int i = 0; i < 3; i++) begin
      out_m[i] = '0;
      dir_m[i] = '0;
      pin_m[i] = '0;
    end
    for (int i = 0; i < 8; i++)
      @(negedge clk);
    resetq = 1'b1;

    fd = $fopen("verification/j4_io_stimulus.txt", "r");
    if (fd == 0)
      abort_run("Could not open the stimulus file");
    lines = 0;
    while (!$feof(fd)) begin
      if (lines == MAX_LINES)
        abort_run("Stimulus file has more lines than allowed");
      lines++;
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line[0] == "#")
        continue; // Blank or comment
      n = $sscanf(line, "%s %h %d %h %h", op, slot, bitn, data, want);
      if (n != 5)
        abort_run($sformatf("Stimulus line %0d could not be parsed", lines));
      p = port_of(bitn);
      case (op)
        "W": begin
          bus_write(slot, bitn, data);
          if (bitn <= 7 && bitn != 2 && bitn != 3) begin
            if (bitn % 2 == 1)
              dir_m[p] = data[`J4_IO_PORT_W-1:0];
            else
              out_m[p] = data[`J4_IO_PORT_W-1:0];
            verify_gpio_pins(p); // Drive and enable follow the write
          end
        end
        "R": begin
          bus_read(slot, bitn, got);
          check_word(got, want, $sformatf("read bit %0d slot %0d", bitn, slot));
        end
        "G": begin
          bus_read(slot, bitn, got);
          check_word(got, j4_io_pkg::word_t'(pin_level(p)),
                     $sformatf("pin readback bit %0d", bitn));
          bus_read(slot, bitn + 1, got); // Direction register sits one bit up
          check_word(got, j4_io_pkg::word_t'(dir_m[p]),
                     $sformatf("direction read bit %0d", bitn + 1));
        end
        "P": begin
          random_byte(pins);
          pin_m[p] = pins;
          case (p)
            0:       pmod_in = pins;
            1:       hdr1_in = pins;
            default: hdr2_in = pins;
          endcase
        end
        "O": begin
          case (bitn)
            0: begin
              check_port(pmod_out, data[7:0], "PMOD out");
              check_port(pmod_oe, want[7:0], "PMOD oe");
            end
            4: begin
              check_port(hdr1_out, data[7:0], "HDR1 out");
              check_port(hdr1_oe, want[7:0], "HDR1 oe");
            end
            6: begin
              check_port(hdr2_out, data[7:0], "HDR2 out");
              check_port(hdr2_oe, want[7:0], "HDR2 oe");
            end
            2:       check_port(leds, data[7:0], "LED out");
            default: check_port({5'b0, misc_out}, data[7:0], "misc out");
          endcase
        end
        "K": begin
          check_kill(kill_slot_rq, want[3:0], "kill pulse");
          @(posedge clk);
          @(negedge clk);
          check_kill(kill_slot_rq, '0, "kill after pulse"); // Single cycle only
        end
        "F": flash_miso = data[0];
        "N": begin
          for (int i = 0; i < int'(data); i++) begin
            random_byte(pins);
            random_byte(pins_hi);
            io_req.addr = {pins_hi, pins}; // Address moves, no strobe
            random_byte(pins);
            io_req.data = {pins, pins_hi};
            @(posedge clk);
            @(negedge clk);
            check_word(io_din, '0, "idle io_din");
          end
        end
        default: abort_run($sformatf("Unknown operation on stimulus line %0d", lines));
      endcase
    end
    $fclose(fd);

    if (i_dut.i_checker.fail_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      abort_run("One or more assertions in the checker failed");
    end
  end

endmodule

`default_nettype wire
